/* list.f */
+incdir+include
src/acq_pkg.sv
src/capture_if.sv
src/trigger_combiner.sv
src/capture_ctrl.sv
src/sample_ring.sv
src/acq_top.sv
testbench/acq_checker.sv
testbench/acq_chk.sv
testbench/acq_tb.sv

/* testbench/acq_tb.sv */
// testbench for the acquisition trigger subsystem: clock, reset, trigger table and captures.
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_tb;
  import acq_pkg::*;

  typedef struct packed {
    trig_mode_t mode;
    trig_t      mask;
    trig_t      pattern;
    logic       hit;
  } row_t;

  localparam int num_rows = 13;

  // OR cases use masks 01 and 0a, AND cases 01 and 90, then the zero masks.
  row_t rows [num_rows] = '{
    '{mode_or,  8'h01, 8'h01, 1'b1},
    '{mode_or,  8'h01, 8'hfe, 1'b0},
    '{mode_or,  8'h0a, 8'h02, 1'b1},
    '{mode_or,  8'h0a, 8'h08, 1'b1},
    '{mode_or,  8'h0a, 8'hf5, 1'b0},
    '{mode_and, 8'h01, 8'h01, 1'b1},
    '{mode_and, 8'h01, 8'h02, 1'b0},
    '{mode_and, 8'h90, 8'h90, 1'b1},
    '{mode_and, 8'h90, 8'h10, 1'b0},
    '{mode_and, 8'h90, 8'h80, 1'b0},
    '{mode_and, 8'h90, 8'hff, 1'b1},
    '{mode_or,  8'h00, 8'hff, 1'b0},
    '{mode_and, 8'h00, 8'hff, 1'b0}
  };

  logic       clk;
  logic       rst_n;
  logic       config_valid;
  logic       arm;
  logic       sample_valid;
  trig_mode_t config_mode;
  trig_t      config_mask;
  trig_t      triggers_in;
  sample_t    sample_in;
  sample_t    read_data;
  addr_t      read_addr;
  addr_t      trigger_pos;
  logic       busy;
  logic       done;
  int         tests = 0;
  int         failed = 0;
  int         errs_before = 0;
  bit         seen;

  acq_top dut_i (.*);

  acq_checker monitor_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #1_000_000;
    $display("simulation stopped by the watchdog before the tests completed");
    $display("Test failures found");
    $finish;
  end

  function automatic int error_count();
    return monitor_i.errors + dut_i.capture_ctrl_i.chk_i.fails;
  endfunction

  // every task enters and leaves just after a rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    sample_in = sample_in + 1'b1;
  endtask

  task automatic configure(input trig_mode_t mode, input trig_t mask);
    config_valid = 1'b1;
    config_mode  = mode;
    config_mask  = mask;
    next_cycle();
    config_valid = 1'b0;
  endtask

  task automatic arm_capture();
    arm       = 1'b1;
    sample_in = sample_t'($urandom());
    next_cycle();
    arm = 1'b0;
  endtask

  task automatic pulse_pattern(input trig_t pattern);
    triggers_in = pattern;
    next_cycle();
    triggers_in = '0;
  endtask

  task automatic wait_done(input int limit, output bit got);
    int i;
    got = 1'b0;
    for (i = 0; (i < limit) && !got; i++) begin
      @(negedge clk);
      got = done;
      next_cycle();
    end
  endtask

  // trigger sample plus the post-trigger window.
  task automatic read_window();
    addr_t base;
    int    i;
    base = trigger_pos;
    for (i = 0; i <= `ACQ_POST_SAMPLES; i++) begin
      read_addr = base + addr_t'(i);
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic report_test(input string what);
    tests++;
    if (error_count() == errs_before) begin
      $display("test %0d %s: ok", tests, what);
    end else begin
      failed++;
      $display("test %0d %s: failed", tests, what);
    end
    errs_before = error_count();
  endtask

  initial begin
    int r;
    rst_n        = 1'b0;
    config_valid = 1'b0;
    config_mode  = mode_or;
    config_mask  = '0;
    triggers_in  = '0;
    arm          = 1'b0;
    sample_valid = 1'b0;
    sample_in    = '0;
    read_addr    = '0;
    void'($urandom(17109));
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // samples stream all the time, the controller drops them while idle.
    sample_valid = 1'b1;
    repeat (3) next_cycle();
    report_test("reset state");
    for (r = 0; r < num_rows; r++) begin
      configure(rows[r].mode, rows[r].mask);
      arm_capture();
      repeat (2) next_cycle();
      pulse_pattern(rows[r].pattern);
      wait_done(rows[r].hit ? 60 : 40, seen);
      monitor_i.check_outcome(tests + 1, rows[r].hit, seen);
      if (seen) read_window();
      report_test($sformatf("%s mask %h pattern %h", (rows[r].mode == mode_and) ? "and" : "or",
                            rows[r].mask, rows[r].pattern));
    end
    // re-arm inside the post-trigger window, done then needs a fresh trigger.
    configure(mode_or, 8'h01);
    arm_capture();
    repeat (2) next_cycle();
    pulse_pattern(8'h01);
    repeat (5) next_cycle();
    arm_capture();
    wait_done(30, seen);
    monitor_i.check_outcome(tests + 1, 1'b0, seen);
    pulse_pattern(8'h01);
    wait_done(60, seen);
    monitor_i.check_outcome(tests + 1, 1'b1, seen);
    if (seen) read_window();
    report_test("re-arm mid capture");
    $display("%0d tests run, %0d failed, %0d errors", tests, failed, error_count());
    if (error_count() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* testbench/acq_chk.sv */
// capture protocol assertions, bound into the capture controller.
`timescale 1ns/1ps

module acq_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                arm,
  input logic                busy,
  input logic                done,
  input logic                write_en,
  input acq_pkg::cap_state_t state
);
  import acq_pkg::*;

  int   fails = 0;
  logic armed_once;

  // remembers whether any arm strobe has been seen since reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_once <= 1'b0;
    end else if (arm) begin
      armed_once <= 1'b1;
    end
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      fails++;
      $error("done stayed high for more than one cycle");
    end

  no_idle_write: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_idle) |-> !write_en)
    else begin
      fails++;
      $error("ring write while the capture FSM is idle");
    end

  idle_until_arm: assert property (@(posedge clk) disable iff (!rst_n) !armed_once |-> !busy)
    else begin
      fails++;
      $error("busy raised before the first arm strobe");
    end

endmodule

bind capture_ctrl acq_chk chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .arm      (arm),
  .busy     (busy),
  .done     (done),
  .write_en (write_en),
  .state    (state)
);

/* testbench/acq_checker.sv */
// capture monitor: models the trigger rule and capture window and compares the DUT outputs.
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                config_valid,
  input acq_pkg::trig_mode_t config_mode,
  input acq_pkg::trig_t      config_mask,
  input acq_pkg::trig_t      triggers_in,
  input logic                arm,
  input logic                sample_valid,
  input acq_pkg::sample_t    sample_in,
  input acq_pkg::addr_t      read_addr,
  input acq_pkg::sample_t    read_data,
  input logic                busy,
  input logic                done,
  input acq_pkg::addr_t      trigger_pos
);
  import acq_pkg::*;

  int         errors = 0;
  sample_t    mem_m [`ACQ_DEPTH];
  bit         written [`ACQ_DEPTH];
  trig_mode_t mode_m;
  trig_t      mask_m;
  trig_t      masked;
  cap_state_t state_m;
  logic [1:0] hit_pipe;
  addr_t      wcount;
  addr_t      pos_m;
  addr_t      ra_q;
  logic       pending;
  logic       done_m;
  logic       rd_ok;
  logic       wr;
  logic       hit_c;
  int         left;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  task automatic check_outcome(input int test, input bit exp_hit, input bit seen_done);
    if (exp_hit != seen_done) begin
      errors++;
      if (exp_hit) begin
        $display("test %0d: no done arrived within the timeout", test);
      end else begin
        $display("test %0d: done arrived although the pattern must not trigger", test);
      end
    end
  endtask

  // sampled mid cycle, so inputs and outputs are both settled.
  always @(negedge clk) begin
    if (!rst_n) begin
      mode_m   = mode_or;
      mask_m   = '0;
      state_m  = st_idle;
      hit_pipe = '0;
      wcount   = '0;
      pos_m    = '0;
      pending  = 1'b0;
      done_m   = 1'b0;
      rd_ok    = 1'b0;
      left     = 0;
    end else begin
      if (busy !== (state_m != st_idle)) report_mismatch("busy", state_m != st_idle, busy);
      if (done !== done_m) report_mismatch("done", done_m, done);
      if (trigger_pos !== pos_m) report_mismatch("trigger_pos", pos_m, trigger_pos);
      if (rd_ok && (read_data !== mem_m[ra_q])) begin
        report_mismatch("read_data", mem_m[ra_q], read_data);
      end
      // a read is only predictable when no write lands on the same edge.
      rd_ok = (state_m == st_idle) && written[read_addr];
      ra_q  = read_addr;
      wr    = sample_valid && (state_m != st_idle);
      if (wr) begin
        mem_m[wcount]   = sample_in;
        written[wcount] = 1'b1;
      end
      done_m = 1'b0;
      if (arm) begin
        state_m = st_armed;
        pending = 1'b0;
      end else if ((state_m == st_armed) && hit_pipe[1]) begin
        state_m = st_post;
        pending = !sample_valid;
        left    = `ACQ_POST_SAMPLES;
        if (sample_valid) pos_m = wcount;
      end else if ((state_m == st_post) && sample_valid) begin
        if (pending) begin
          pending = 1'b0;
          pos_m   = wcount;
        end else begin
          left--;
          if (left == 0) begin
            state_m = st_idle;
            done_m  = 1'b1;
          end
        end
      end
      if (wr) wcount = wcount + 1'b1;
      // trigger rule, the hit shows up two cycles after the vector.
      if (config_valid) begin
        mode_m = config_mode;
        mask_m = config_mask;
      end
      masked = triggers_in & mask_m;
      if (mask_m == '0) hit_c = 1'b0;
      else if (mode_m == mode_and) hit_c = (masked == mask_m);
      else hit_c = (masked != '0);
      hit_pipe = {hit_pipe[0], hit_c};
    end
  end

endmodule

/* src/acq_top.sv */
// acquisition top level: trigger combiner, capture controller and sample ring.
`timescale 1ns/1ps

module acq_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                config_valid,
  input  acq_pkg::trig_mode_t config_mode,
  input  acq_pkg::trig_t      config_mask,
  input  acq_pkg::trig_t      triggers_in,
  input  logic                arm,
  input  logic                sample_valid,
  input  acq_pkg::sample_t    sample_in,
  input  acq_pkg::addr_t      read_addr,
  output acq_pkg::sample_t    read_data,
  output logic                busy,
  output logic                done,
  output acq_pkg::addr_t      trigger_pos
);

  logic trigger_hit;

  // write path between controller and ring.
  capture_if cap_i ();

  trigger_combiner trigger_combiner_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .config_valid (config_valid),
    .config_mode  (config_mode),
    .config_mask  (config_mask),
    .triggers_in  (triggers_in),
    .trigger_hit  (trigger_hit)
  );

  capture_ctrl capture_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .arm          (arm),
    .sample_valid (sample_valid),
    .trigger_hit  (trigger_hit),
    .cap          (cap_i.ctrl),
    .busy         (busy),
    .done         (done),
    .trigger_pos  (trigger_pos)
  );

  sample_ring sample_ring_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cap       (cap_i.ring),
    .sample_in (sample_in),
    .read_addr (read_addr),
    .read_data (read_data)
  );

endmodule

/* src/sample_ring.sv */
// sample ring: circular sample store with a wrapping write pointer and a synchronous read port.
`timescale 1ns/1ps
`include "acq_cfg.svh"

module sample_ring (
  input  logic             clk,
  input  logic             rst_n,
  capture_if.ring          cap,
  input  acq_pkg::sample_t sample_in,
  input  acq_pkg::addr_t   read_addr,
  output acq_pkg::sample_t read_data
);
  import acq_pkg::*;

  sample_t mem [`ACQ_DEPTH];
  addr_t   wr_ptr;

  // pointer wraps by overflow since depth is a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (cap.write_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  assign cap.wr_ptr = wr_ptr;

  // storage array.
  always_ff @(posedge clk) begin
    if (cap.write_en) begin
      mem[wr_ptr] <= sample_in;
    end
  end

  // readout, data follows the address by one cycle.
  always_ff @(posedge clk) begin
    read_data <= mem[read_addr];
  end

endmodule

/* src/capture_ctrl.sv */
// capture controller: arming and post-trigger FSM that gates ring writes and finds the trigger.
`timescale 1ns/1ps
`include "acq_cfg.svh"

module capture_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           arm,
  input  logic           sample_valid,
  input  logic           trigger_hit,
  capture_if.ctrl        cap,
  output logic           busy,
  output logic           done,
  output acq_pkg::addr_t trigger_pos
);
  import acq_pkg::*;

  localparam post_cnt_t last_post = post_cnt_t'(`ACQ_POST_SAMPLES - 1);

  cap_state_t state;
  cap_state_t state_nxt;
  post_cnt_t  post_cnt;
  logic       pending;
  logic       take_hit;
  logic       write_en;
  logic       post_write;
  logic       last_write;

  // a hit only counts while armed and not being re-armed.
  assign take_hit = !arm && trigger_hit && (state == st_armed);

  assign write_en = sample_valid && (state != st_idle);

  // trigger sample is either the one coinciding with the hit,
  // or the first valid sample after it.
  assign cap.mark = !arm && sample_valid &&
                    (take_hit || ((state == st_post) && pending));

  // writes after the trigger sample fill the post-trigger window.
  assign post_write = !arm && sample_valid && (state == st_post) && !pending;
  assign last_write = post_write && (post_cnt == last_post);

  assign cap.write_en = write_en;
  assign busy         = (state != st_idle);

  always_comb begin
    state_nxt = state;
    if (arm) begin
      state_nxt = st_armed;
    end else begin
      case (state)
        st_armed: if (trigger_hit) state_nxt = st_post;
        st_post:  if (last_write) state_nxt = st_idle;
        default:  state_nxt = st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      pending  <= 1'b0;
      post_cnt <= '0;
      done     <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= last_write;
      if (arm) begin
        pending  <= 1'b0;
        post_cnt <= '0;
      end else if (take_hit) begin
        // no sample this cycle, wait for the next one.
        pending  <= !sample_valid;
        post_cnt <= '0;
      end else begin
        if (cap.mark) begin
          pending <= 1'b0;
        end
        if (post_write) begin
          post_cnt <= post_cnt + 4'd1;
        end
      end
    end
  end

  // ring address of the trigger sample, taken before the pointer moves.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trigger_pos <= '0;
    end else if (cap.mark) begin
      trigger_pos <= cap.wr_ptr;
    end
  end

endmodule

/* src/trigger_combiner.sv */
// trigger combiner: masks the channel triggers and merges them in OR or AND mode.
`timescale 1ns/1ps

module trigger_combiner (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                config_valid,
  input  acq_pkg::trig_mode_t config_mode,
  input  acq_pkg::trig_t      config_mask,
  input  acq_pkg::trig_t      triggers_in,
  output logic                trigger_hit
);
  import acq_pkg::*;

  trig_mode_t mode;
  trig_t      mask;
  trig_t      trig_q;
  trig_t      masked;
  logic       hit_any;
  logic       hit_all;
  logic       hit_nxt;

  // configuration registers, loaded by the one-cycle strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode <= mode_or;
      mask <= '0;
    end else if (config_valid) begin
      mode <= config_mode;
      mask <= config_mask;
    end
  end

  // first stage holds the raw channel vector.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_q <= '0;
    end else begin
      trig_q <= triggers_in;
    end
  end

  assign masked  = trig_q & mask;
  assign hit_any = |masked;
  assign hit_all = (masked == mask);

  // an empty mask disables the combiner in both modes.
  always_comb begin
    if (mask == '0) begin
      hit_nxt = 1'b0;
    end else if (mode == mode_and) begin
      hit_nxt = hit_all;
    end else begin
      hit_nxt = hit_any;
    end
  end

  // second stage, hit is seen one cycle after the vector was sampled.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trigger_hit <= 1'b0;
    end else begin
      trigger_hit <= hit_nxt;
    end
  end

endmodule

/* src/capture_if.sv */
// capture interface carrying write control from the capture FSM to the sample ring.
`timescale 1ns/1ps

interface capture_if;
  import acq_pkg::*;

  // sample_valid qualified by the capture state.
  logic  write_en;

  // high on the write that stores the trigger sample.
  logic  mark;

  // address the next write will land on.
  addr_t wr_ptr;

  modport ctrl (
    output write_en,
    output mark,
    input  wr_ptr
  );

  // the ring only needs the write strobe, mark stays with the controller.
  modport ring (
    input  write_en,
    output wr_ptr
  );

endinterface

/* src/acq_pkg.sv */
// acquisition package with the datapath vector types and the capture FSM states.
`include "acq_cfg.svh"

package acq_pkg;

  // one bit per trigger channel.
  typedef logic [`ACQ_CHANNELS-1:0] trig_t;

  // one data sample and one ring address.
  typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;
  typedef logic [`ACQ_ADDR_W-1:0]   addr_t;

  // counts the samples written after the trigger sample.
  typedef logic [3:0] post_cnt_t;

  typedef enum logic {
    mode_or  = 1'b0,
    mode_and = 1'b1
  } trig_mode_t;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_armed = 2'd1,
    st_post  = 2'd2
  } cap_state_t;

endpackage

/* include/acq_cfg.svh */
// acquisition trigger configuration: channel count, sample width, ring size, post-trigger length.
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// trigger channels and sample width.
`define ACQ_CHANNELS 8
`define ACQ_SAMPLE_W 16

// ring memory geometry, depth must equal 2**ACQ_ADDR_W.
`define ACQ_DEPTH 32
`define ACQ_ADDR_W 5

// samples kept after the trigger sample.
`define ACQ_POST_SAMPLES 8

`endif
